//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --assert -f project.f --top-module sensorHubTb -o simv
	out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall -f project.f --top-module sensorHubTb

clean:
	rm -rf obj_dir

//--- logic/beaconCapture.sv
`timescale 1ns/1ns
`default_nettype none
`include "sensorHub_params.svh"

module beaconCapture (
	input  logic                   CLOCK_50,
	input  logic                   reset,
	input  logic                   beaconSign,
	input  logic                   beaconSync,
	input  logic                   turretA,
	output sensorHubPkg::positionT beaconStart,
	output sensorHubPkg::positionT beaconEnd,
	output logic                   turnFlag
);

	localparam int signIdx = 0;
	localparam int syncIdx = 1;
	localparam int turretIdx = 2;
	localparam int gapW = $clog2(`GLITCH_TICKS + 1);

	logic [2:0] syncStage1;
	logic [2:0] syncStage2;
	logic [2:0] prevLevel;
	logic [2:0] rise;
	logic signFall;
	sensorHubPkg::positionT position;
	sensorHubPkg::positionT startPos;
	sensorHubPkg::positionT endPos;
	logic [gapW-1:0] gapTicks;
	sensorHubPkg::beaconStateT state;

	// ==============================
	// synchronizers and edge detect
	// ==============================
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			syncStage1 <= '0;
			syncStage2 <= '0;
			prevLevel <= '0;
		end else begin
			syncStage1 <= {turretA, beaconSync, beaconSign};
			syncStage2 <= syncStage1;
			prevLevel <= syncStage2;
		end
	end

	assign rise = syncStage2 & ~prevLevel;
	assign signFall = ~syncStage2[signIdx] & prevLevel[signIdx];

	// turret position, zeroed once per revolution
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			position <= '0;
			turnFlag <= 1'b0;
		end else if (rise[syncIdx]) begin
			position <= '0;
			turnFlag <= ~turnFlag;
		end else if (rise[turretIdx]) begin
			position <= position + 1'b1;
		end
	end

	// ==============================
	// beacon pulse FSM
	// ==============================
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			state <= sensorHubPkg::beaconIdle;
			gapTicks <= '0;
			beaconStart <= '0;
			beaconEnd <= '0;
		end else begin
			case (state)
				sensorHubPkg::beaconIdle: begin
					if (rise[signIdx])
						state <= sensorHubPkg::beaconReceiving;
				end
				sensorHubPkg::beaconReceiving: begin
					if (signFall) begin
						gapTicks <= '0;
						state <= sensorHubPkg::beaconGap;
					end
				end
				sensorHubPkg::beaconGap: begin
					if (syncStage2[signIdx]) begin
						state <= sensorHubPkg::beaconReceiving; // dropout bridged
					end else if (rise[turretIdx]) begin
						if (gapTicks == gapW'(`GLITCH_TICKS - 1)) begin
							beaconStart <= startPos;
							beaconEnd <= endPos;
							state <= sensorHubPkg::beaconIdle;
						end else begin
							gapTicks <= gapTicks + 1'b1;
						end
					end
				end
				default: state <= sensorHubPkg::beaconIdle;
			endcase
		end
	end

	// tentative positions, published only when the gap times out
	always_ff @(posedge CLOCK_50) begin
		if (state == sensorHubPkg::beaconIdle && rise[signIdx])
			startPos <= position;
		if (state == sensorHubPkg::beaconReceiving && signFall)
			endPos <= position;
	end

	stateLegal: assert property (@(posedge CLOCK_50) disable iff (reset)
		state inside {sensorHubPkg::beaconIdle, sensorHubPkg::beaconReceiving,
			sensorHubPkg::beaconGap});

endmodule

`default_nettype wire

//--- logic/encoderChannel.sv
`timescale 1ns/1ns
`default_nettype none
`include "sensorHub_params.svh"

module encoderChannel #(
	parameter bit invertDirection = 1'b0
) (
	input  logic                CLOCK_50,
	input  logic                reset,
	input  logic                encA,
	input  logic                encB,
	input  logic                windowEnd,
	output sensorHubPkg::speedT speed,
	output logic                direction
);

	logic [1:0] aSync;
	logic [1:0] bSync;
	logic aPrev;
	logic bPrev;
	logic aRise;
	logic bRise;
	sensorHubPkg::speedT cntA;
	sensorHubPkg::speedT cntB;
	logic [`SPEED_W:0] edgeSum;                  // one extra bit so the sum cannot wrap

	// ==============================
	// synchronizers and edge detect
	// ==============================
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			aSync <= '0;
			bSync <= '0;
			aPrev <= 1'b0;
			bPrev <= 1'b0;
		end else begin
			aSync <= {aSync[0], encA};
			bSync <= {bSync[0], encB};
			aPrev <= aSync[1];
			bPrev <= bSync[1];
		end
	end

	assign aRise = aSync[1] & ~aPrev;
	assign bRise = bSync[1] & ~bPrev;
	assign edgeSum = {1'b0, cntA} + {1'b0, cntB};

	// edge counters, saturating
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			cntA <= '0;
			cntB <= '0;
			speed <= '0;
		end else if (windowEnd) begin
			speed <= edgeSum[`SPEED_W:1];        // halved sum of both phases
			cntA <= sensorHubPkg::speedT'(aRise); // coinciding edge opens the next window
			cntB <= sensorHubPkg::speedT'(bRise);
		end else begin
			if (aRise && cntA != '1)
				cntA <= cntA + 1'b1;
			if (bRise && cntB != '1)
				cntB <= cntB + 1'b1;
		end
	end

	// B level seen at each rise of A
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset)
			direction <= 1'b0;
		else if (aRise)
			direction <= bSync[1] ^ invertDirection;
	end

endmodule

`default_nettype wire

//--- logic/sensorHub.sv
`timescale 1ns/1ns
`default_nettype none
`include "sensorHub_params.svh"

module sensorHub #(
	parameter int windowCycles = `SPEED_WINDOW_CYCLES
) (
	input  logic                        CLOCK_50,
	input  logic                        reset,
	input  sensorHubPkg::encBitsT      encA,
	input  sensorHubPkg::encBitsT      encB,
	input  logic                        beaconSign,
	input  logic                        beaconSync,
	input  logic                        turretA,
	input  sensorHubPkg::switchT       limitSwitch,
	input  logic                        startCord,
	input  logic                        robotId,
	output sensorHubPkg::sensorReportT report,
	output logic                        reportValid,
	input  logic                        reportReady
);

	localparam sensorHubPkg::encBitsT dirInvert = `DIR_INVERT;

	sensorHubPkg::speedT [`NUM_ENC-1:0] speeds;
	sensorHubPkg::encBitsT directions;
	sensorHubPkg::positionT beaconStart;
	sensorHubPkg::positionT beaconEnd;
	logic turnFlag;
	logic windowEnd;

	// ==============================
	// encoder counting
	// ==============================
	genvar ch;
	generate
		for (ch = 0; ch < `NUM_ENC; ch++) begin : encGen
			encoderChannel #(
				.invertDirection(dirInvert[ch])
			) encoder (
				.CLOCK_50(CLOCK_50),
				.reset(reset),
				.encA(encA[ch]),
				.encB(encB[ch]),
				.windowEnd(windowEnd),
				.speed(speeds[ch]),
				.direction(directions[ch])
			);
		end
	endgenerate

	// beacon glitch handling
	beaconCapture beacon (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.beaconSign(beaconSign),
		.beaconSync(beaconSync),
		.turretA(turretA),
		.beaconStart(beaconStart),
		.beaconEnd(beaconEnd),
		.turnFlag(turnFlag)
	);

	// data assembly toward the host
	speedSnapshot #(
		.windowCycles(windowCycles)
	) snapshot (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.speeds(speeds),
		.directions(directions),
		.beaconStart(beaconStart),
		.beaconEnd(beaconEnd),
		.turnFlag(turnFlag),
		.limitSwitch(limitSwitch),
		.startCord(startCord),
		.robotId(robotId),
		.windowEnd(windowEnd),
		.report(report),
		.reportValid(reportValid),
		.reportReady(reportReady)
	);

endmodule

`default_nettype wire

//--- logic/sensorHubPkg.sv
`default_nettype none
`include "sensorHub_params.svh"

package sensorHubPkg;

	// ==============================
	// field types
	// ==============================
	typedef logic [`SPEED_W-1:0] speedT;
	typedef logic [`POS_W-1:0] positionT;
	typedef logic [`NUM_ENC-1:0] encBitsT;      // one bit per encoder channel
	typedef logic [`NUM_SWITCH-1:0] switchT;

	// beacon pulse tracking
	typedef enum logic [1:0] {
		beaconIdle,
		beaconReceiving,
		beaconGap                                // light lost, maybe only a dropout
	} beaconStateT;

	// one report per measurement window
	typedef struct packed {
		speedT [`NUM_ENC-1:0] speeds;
		encBitsT directions;
		positionT beaconStart;
		positionT beaconEnd;
		logic turnFlag;
		switchT limitSwitch;
		logic startCord;
		logic robotId;
		logic overrun;                           // at least one window dropped before this one
	} sensorReportT;

endpackage

`default_nettype wire

//--- logic/sensorHub_params.svh
`ifndef SENSORHUB_PARAMS_SVH
`define SENSORHUB_PARAMS_SVH

// ==============================
// datapath widths
// ==============================
`define SPEED_W 16               // speed value and edge counters
`define POS_W 16                 // turret position

`define NUM_ENC 7                // quadrature channels
`define NUM_SWITCH 5             // limit switches

// measurement window, 10 ms at 50 MHz
`define SPEED_WINDOW_CYCLES 500000

// turret ticks without beacon light that close a pulse
`define GLITCH_TICKS 20

// channel order: propLeft, propRight, rakeLeft, rakeRight, gripper, odoLeft, odoRight
// right propulsion wheel and left odometer count backwards
`define DIR_INVERT 7'b010_0010

`endif

//--- logic/speedSnapshot.sv
`timescale 1ns/1ns
`default_nettype none
`include "sensorHub_params.svh"

module speedSnapshot #(
	parameter int windowCycles = `SPEED_WINDOW_CYCLES
) (
	input  logic                                CLOCK_50,
	input  logic                                reset,
	input  sensorHubPkg::speedT [`NUM_ENC-1:0] speeds,
	input  sensorHubPkg::encBitsT              directions,
	input  sensorHubPkg::positionT             beaconStart,
	input  sensorHubPkg::positionT             beaconEnd,
	input  logic                                turnFlag,
	input  sensorHubPkg::switchT               limitSwitch,
	input  logic                                startCord,
	input  logic                                robotId,
	output logic                                windowEnd,
	output sensorHubPkg::sensorReportT         report,
	output logic                                reportValid,
	input  logic                                reportReady
);

	localparam int timerW = $clog2(windowCycles);
	localparam int miscW = `NUM_SWITCH + 2;      // switches, cord and id

	logic [timerW-1:0] timer;
	logic [miscW-1:0] miscSync1;
	logic [miscW-1:0] miscSync2;
	logic [miscW-1:0] miscHold;
	logic windowEndD;
	logic canLoad;
	logic overrunFlag;

	// ==============================
	// window timer
	// ==============================
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			timer <= '0;
			windowEndD <= 1'b0;
			miscSync1 <= '0;
			miscSync2 <= '0;
		end else begin
			timer <= windowEnd ? '0 : timer + 1'b1;
			windowEndD <= windowEnd;             // channels load speed on windowEnd
			miscSync1 <= {limitSwitch, startCord, robotId};
			miscSync2 <= miscSync1;
		end
	end

	assign windowEnd = (timer == timerW'(windowCycles - 1));
	assign canLoad = ~reportValid | reportReady;

	always_ff @(posedge CLOCK_50) begin
		if (windowEnd)
			miscHold <= miscSync2;
	end

	// handshake and overrun bookkeeping
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			reportValid <= 1'b0;
			overrunFlag <= 1'b0;
		end else if (windowEndD) begin
			if (canLoad) begin
				reportValid <= 1'b1;
				overrunFlag <= 1'b0;             // moves into the new report
			end else begin
				overrunFlag <= 1'b1;             // host still busy, window lost
			end
		end else if (reportValid && reportReady) begin
			reportValid <= 1'b0;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (windowEndD && canLoad) begin
			report.speeds <= speeds;
			report.directions <= directions;
			report.beaconStart <= beaconStart;
			report.beaconEnd <= beaconEnd;
			report.turnFlag <= turnFlag;
			report.limitSwitch <= miscHold[miscW-1:2];
			report.startCord <= miscHold[1];
			report.robotId <= miscHold[0];
			report.overrun <= overrunFlag;
		end
	end

	reportHeld: assert property (@(posedge CLOCK_50) disable iff (reset)
		reportValid && !reportReady |=> reportValid && $stable(report));

	windowPulse: assert property (@(posedge CLOCK_50) disable iff (reset)
		windowEnd |=> !windowEnd);

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/sensorHubPkg.sv
logic/encoderChannel.sv
logic/beaconCapture.sv
logic/speedSnapshot.sv
logic/sensorHub.sv
verif/sensorHubChecker.sv
verif/sensorHubTb.sv

//--- verif/sensorHubChecker.sv
`timescale 1ns/1ns
`default_nettype none
`include "sensorHub_params.svh"

module sensorHubChecker #(
	parameter int windowCycles = 400
) (
	input wire logic                        CLOCK_50,
	input wire logic                        reset,
	input wire sensorHubPkg::encBitsT      encA,
	input wire sensorHubPkg::encBitsT      encB,
	input wire logic                        beaconSign,
	input wire logic                        beaconSync,
	input wire logic                        turretA,
	input wire sensorHubPkg::switchT       limitSwitch,
	input wire logic                        startCord,
	input wire logic                        robotId,
	input wire sensorHubPkg::sensorReportT report,
	input wire logic                        reportValid,
	input wire logic                        reportReady
);

	localparam sensorHubPkg::encBitsT dirInvert = `DIR_INVERT;

	int errors = 0;
	int reportsChecked = 0;
	int windowsClosed = 0;
	int windowsDropped = 0;
	int pendingReports = 0;
	sensorHubPkg::sensorReportT expQ[$];
	sensorHubPkg::sensorReportT snap;
	sensorHubPkg::sensorReportT held;
	logic heldValid;
	logic pushedLast;
	logic stickyOverrun;
	int cyc;
	int cntA[`NUM_ENC];
	int cntB[`NUM_ENC];
	sensorHubPkg::encBitsT dirBits;
	sensorHubPkg::encBitsT prevA;
	sensorHubPkg::encBitsT prevB;
	logic prevSign;
	logic prevSync;
	logic prevTurret;
	logic parity;
	sensorHubPkg::positionT pos;
	sensorHubPkg::positionT tentStart;
	sensorHubPkg::positionT tentEnd;
	sensorHubPkg::positionT pubStart;
	sensorHubPkg::positionT pubEnd;
	int gapCnt;
	sensorHubPkg::beaconStateT bState;

	task automatic checkField(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic compareReport(input sensorHubPkg::sensorReportT exp);
		for (int ch = 0; ch < `NUM_ENC; ch++)
			checkField($sformatf("speed[%0d]", ch), 32'(exp.speeds[ch]), 32'(report.speeds[ch]));
		checkField("directions", 32'(exp.directions), 32'(report.directions));
		checkField("beaconStart", 32'(exp.beaconStart), 32'(report.beaconStart));
		checkField("beaconEnd", 32'(exp.beaconEnd), 32'(report.beaconEnd));
		checkField("turnFlag", 32'(exp.turnFlag), 32'(report.turnFlag));
		checkField("limitSwitch", 32'(exp.limitSwitch), 32'(report.limitSwitch));
		checkField("startCord", 32'(exp.startCord), 32'(report.startCord));
		checkField("robotId", 32'(exp.robotId), 32'(report.robotId));
		checkField("overrun", 32'(exp.overrun), 32'(report.overrun));
		reportsChecked++;
	endtask

	// ==============================
	// reference model, raw input edges
	// ==============================
	always @(posedge CLOCK_50) begin
		if (reset) begin
			cyc = 0;
			dirBits = '0;
			prevA = '0;
			prevB = '0;
			{prevSign, prevSync, prevTurret, parity} = '0;
			{pos, pubStart, pubEnd, tentStart, tentEnd} = '0;
			bState = sensorHubPkg::beaconIdle;
			{heldValid, pushedLast, stickyOverrun} = '0;
			gapCnt = 0;
			for (int ch = 0; ch < `NUM_ENC; ch++) begin
				cntA[ch] = 0;
				cntB[ch] = 0;
			end
		end else begin
			cyc++;
			if (heldValid && !reportValid) begin
				errors++;
				$display("reportValid dropped before the host took the report");
			end else if (heldValid && report !== held) begin
				errors++;
				$display("ERR report changed while held, was %h now %h", held, report);
			end
			heldValid = reportValid && !reportReady;
			held = report;
			if (reportValid && reportReady) begin
				if (expQ.size() == 0) begin
					errors++;
					$display("host took a report although no window was pending");
				end else begin
					compareReport(expQ.pop_front());
				end
			end
			for (int ch = 0; ch < `NUM_ENC; ch++) begin
				if (encA[ch] && !prevA[ch]) begin
					cntA[ch]++;
					dirBits[ch] = encB[ch] ^ dirInvert[ch]; // B level at A rise
				end
				if (encB[ch] && !prevB[ch])
					cntB[ch]++;
			end
			case (bState)
				sensorHubPkg::beaconIdle: begin
					if (beaconSign && !prevSign) begin
						tentStart = pos;
						bState = sensorHubPkg::beaconReceiving;
					end
				end
				sensorHubPkg::beaconReceiving: begin
					if (!beaconSign && prevSign) begin
						tentEnd = pos;
						gapCnt = 0;
						bState = sensorHubPkg::beaconGap;
					end
				end
				default: begin
					if (beaconSign) begin
						bState = sensorHubPkg::beaconReceiving; // short dropout
					end else if (turretA && !prevTurret) begin
						if (gapCnt == `GLITCH_TICKS - 1) begin
							pubStart = tentStart;
							pubEnd = tentEnd;
							bState = sensorHubPkg::beaconIdle;
						end else begin
							gapCnt++;
						end
					end
				end
			endcase
			if (beaconSync && !prevSync) begin
				pos = '0;
				parity = ~parity;
			end else if (turretA && !prevTurret) begin
				pos = pos + 1'b1;
			end
			prevA = encA;
			prevB = encB;
			{prevSign, prevSync, prevTurret} = {beaconSign, beaconSync, turretA};

			// window boundary, speeds and switches
			if (cyc % windowCycles == 0) begin
				for (int ch = 0; ch < `NUM_ENC; ch++) begin
					snap.speeds[ch] = sensorHubPkg::speedT'((cntA[ch] + cntB[ch]) / 2);
					cntA[ch] = 0;
					cntB[ch] = 0;
				end
				snap.directions = dirBits;
				snap.limitSwitch = limitSwitch;
				snap.startCord = startCord;
				snap.robotId = robotId;
			end
			if (cyc % windowCycles == 1 && cyc > 1) begin
				snap.beaconStart = pubStart;
				snap.beaconEnd = pubEnd;
				snap.turnFlag = parity;
				windowsClosed++;
				pushedLast = !reportValid || reportReady;
				if (pushedLast) begin
					snap.overrun = stickyOverrun;
					stickyOverrun = 1'b0;
					expQ.push_back(snap);
				end else begin
					stickyOverrun = 1'b1;         // host busy, window lost
					windowsDropped++;
				end
			end
			if (cyc % windowCycles == 2 && cyc > 2 && pushedLast && !reportValid) begin
				errors++;
				$display("report for window %0d did not appear", windowsClosed - 1);
			end
			pendingReports = expQ.size();
		end
	end

endmodule

`default_nettype wire

//--- verif/sensorHubTb.sv
`timescale 1ns/1ns
`default_nettype none
`include "sensorHub_params.svh"

module sensorHubTb;

	localparam int windowLen = 400;
	localparam int numWin = 8;
	localparam int slots = 22;                   // turret ticks per window
	localparam int timeoutLimit = numWin * windowLen + 2000;

	logic CLOCK_50 = 1'b0;
	logic reset;
	sensorHubPkg::encBitsT encA;
	sensorHubPkg::encBitsT encB;
	logic beaconSign;
	logic beaconSync;
	logic turretA;
	sensorHubPkg::switchT limitSwitch;
	logic startCord;
	logic robotId;
	sensorHubPkg::sensorReportT report;
	logic reportValid;
	logic reportReady;

	int seed = 32'h847c_bb1d;
	int cycles = 0;
	int offA[`NUM_ENC];
	int offB[`NUM_ENC];

	// ==============================
	// stimulus table, one row per window
	// ==============================
	int numA[numWin][`NUM_ENC] = '{'{4, 6, 8, 10, 12, 14, 16}, '{22, 1, 0, 3, 5, 7, 9},
		'{10, 10, 10, 10, 10, 10, 10}, '{0, 2, 4, 6, 8, 20, 22}, '{5, 5, 5, 5, 5, 5, 5},
		'{13, 1, 17, 2, 19, 3, 11}, '{7, 8, 9, 10, 11, 12, 13}, '{15, 0, 15, 0, 15, 0, 15}};
	int numB[numWin][`NUM_ENC] = '{'{4, 6, 8, 10, 12, 14, 16}, '{21, 2, 0, 3, 4, 8, 9},
		'{9, 11, 10, 12, 8, 10, 7}, '{1, 2, 3, 7, 8, 20, 22}, '{5, 5, 5, 5, 5, 5, 5},
		'{12, 2, 16, 3, 18, 4, 10}, '{7, 8, 9, 10, 11, 12, 13}, '{14, 1, 14, 1, 14, 1, 14}};
	logic [`NUM_ENC-1:0] bLead[numWin] = '{7'h55, 7'h2a, 7'h7f, 7'h00, 7'h33, 7'h4c, 7'h12,
		7'h61};                              // B high at A rise
	logic bcnOn[numWin] = '{0, 1, 1, 0, 1, 0, 1, 0};
	int bcnStart[numWin] = '{0, 1, 3, 0, 4, 0, 10, 0};
	int bcnFall[numWin] = '{0, 3, 5, 0, 7, 0, 13, 0};
	int bcnDrop[numWin] = '{0, 3, 19, 0, 20, 0, 2, 0}; // 19 bridged, 20 splits
	int bcnEnd[numWin] = '{0, 6, 26, 0, 30, 0, 16, 0}; // may run into next window
	logic syncOn[numWin] = '{1, 0, 1, 1, 0, 1, 0, 1};
	sensorHubPkg::switchT swRow[numWin] = '{5'h01, 5'h1f, 5'h0a, 5'h15, 5'h00, 5'h13,
		5'h08, 5'h1c};
	logic cordRow[numWin] = '{0, 1, 1, 0, 1, 0, 0, 1};
	logic idRow[numWin] = '{1, 1, 0, 0, 1, 0, 1, 0};
	int readyDelay[numWin] = '{0, 3, 450, 10, 0, 1, 0, 0}; // per accepted report

	sensorHub #(
		.windowCycles(windowLen)
	) DUT (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.encA(encA),
		.encB(encB),
		.beaconSign(beaconSign),
		.beaconSync(beaconSync),
		.turretA(turretA),
		.limitSwitch(limitSwitch),
		.startCord(startCord),
		.robotId(robotId),
		.report(report),
		.reportValid(reportValid),
		.reportReady(reportReady)
	);

	sensorHubChecker #(
		.windowCycles(windowLen)
	) scoreboard (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.encA(encA),
		.encB(encB),
		.beaconSign(beaconSign),
		.beaconSync(beaconSync),
		.turretA(turretA),
		.limitSwitch(limitSwitch),
		.startCord(startCord),
		.robotId(robotId),
		.report(report),
		.reportValid(reportValid),
		.reportReady(reportReady)
	);

	always #20 CLOCK_50 = ~CLOCK_50;

	// beacon light level for an absolute turret tick
	function automatic logic signAt(input int t);
		int b;
		for (int r = 0; r < numWin; r++) begin
			b = r * slots;
			if (bcnOn[r] && ((t >= b + bcnStart[r] && t < b + bcnFall[r]) ||
				(t >= b + bcnFall[r] + bcnDrop[r] && t < b + bcnEnd[r])))
				return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic int pickOffset(input int n);
		int m;
		m = slots + 1 - n;
		return (($random(seed) % m) + m) % m;
	endfunction

	task automatic driveCycle(input int cyc);
		int w;
		int o;
		int k;
		int p;
		w = cyc / windowLen;
		o = cyc % windowLen;
		if (w >= numWin)
			w = numWin - 1;
		if (o == 0 || cyc == 1) begin
			limitSwitch = swRow[w];
			startCord = cordRow[w];
			robotId = idRow[w];
			for (int ch = 0; ch < `NUM_ENC; ch++) begin
				offA[ch] = pickOffset(numA[w][ch]);
				offB[ch] = pickOffset(numB[w][ch]);
			end
		end
		k = (o - 16) / 16;                       // slot index, 16 clocks each
		p = (o - 16) % 16;
		if (o < 16 || k >= slots || cyc >= numWin * windowLen) begin
			encA = '0;
			encB = '0;
			turretA = 1'b0;
			beaconSync = 1'b0;
		end else begin
			for (int ch = 0; ch < `NUM_ENC; ch++) begin
				encA[ch] = k >= offA[ch] && k < offA[ch] + numA[w][ch] &&
					p >= (bLead[w][ch] ? 4 : 0) && p < (bLead[w][ch] ? 12 : 8);
				encB[ch] = k >= offB[ch] && k < offB[ch] + numB[w][ch] &&
					p >= (bLead[w][ch] ? 0 : 4) && p < (bLead[w][ch] ? 8 : 12);
			end
			turretA = p < 8;
			if (p == 8)
				beaconSign = signAt(w * slots + k);
			beaconSync = syncOn[w] && ((k == 0 && p >= 12) || (k == 1 && p < 4));
		end
	endtask

	// host side
	initial begin
		int hs;
		hs = 0;
		reportReady = 1'b0;
		forever begin
			@(posedge CLOCK_50);
			if (reportValid && !reset) begin
				repeat (readyDelay[hs % numWin]) @(posedge CLOCK_50);
				#5 reportReady = 1'b1;
				do
					@(posedge CLOCK_50);
				while (!(reportValid && reportReady));
				#5 reportReady = 1'b0;
				hs++;
			end
		end
	end

	always @(posedge CLOCK_50) begin
		cycles++;
		if (cycles > timeoutLimit) begin
			$display("timeout after %0d cycles, reports still outstanding", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		encA = '0;
		encB = '0;
		{beaconSign, beaconSync, turretA, startCord, robotId} = '0;
		limitSwitch = '0;
		repeat (16) @(posedge CLOCK_50);
		#5 reset = 1'b0;
		for (int cyc = 1; cyc <= numWin * windowLen; cyc++) begin
			@(posedge CLOCK_50);
			#5 driveCycle(cyc);
		end
		while (scoreboard.windowsClosed < numWin || scoreboard.pendingReports != 0)
			@(posedge CLOCK_50);
		repeat (4) @(posedge CLOCK_50);
		$display("errors %0d, reports checked %0d, windows dropped %0d", scoreboard.errors,
			scoreboard.reportsChecked, scoreboard.windowsDropped);
		if (scoreboard.errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
